// ==== hw/vec_pkg.sv ====
/*
 * Vector coprocessor shared definitions
 * Sizes, element and index types, opcodes and the structs passed
 * between dispatcher, sequencer, lanes and slide unit.
 */
package vec_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VLenElems    = 16;
  // Element i sits in lane i mod NrLanes, slot i div NrLanes
  localparam int unsigned SlotsPerLane = VLenElems / NrLanes;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [ElemWidth-1:0]            elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]      vreg_idx_t;
  typedef logic [$clog2(SlotsPerLane)-1:0] slot_idx_t;

  typedef enum logic [2:0] {
    VID,
    VADD_VV,
    VADD_VX,
    VSLIDE1UP,
    VMV_XS
  } vec_op_e;

  // Instruction as sent by the core
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_insn_t;

  // Issue request towards the PEs
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } pe_req_t;

  // One write into a lane's register bank
  typedef struct packed {
    slot_idx_t slot;
    vreg_idx_t vd;
    elem_t     data;
  } vrf_wr_t;

  typedef enum logic {
    PeLanes,
    PeSlide
  } pe_sel_e;

endpackage

// ==== hw/vrf_write_arb.sv ====
`timescale 1ns/10ps

/*
 * Bank write arbiter
 * Round-robin choice between the lane adder and the slide unit.
 */
module vrf_write_arb import vec_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    alu_valid_i,
  input  vrf_wr_t alu_wr_i,
  input  logic    slide_valid_i,
  input  vrf_wr_t slide_wr_i,
  output logic    alu_gnt_o,
  output logic    slide_gnt_o,
  output logic    wr_en_o,
  output vrf_wr_t wr_o
);

  // High when the slide unit won the last write
  logic last_slide_q;

  // On conflict the writer that lost last time goes first
  assign alu_gnt_o   = alu_valid_i & (~slide_valid_i | last_slide_q);
  assign slide_gnt_o = slide_valid_i & ~alu_gnt_o;
  assign wr_en_o     = alu_gnt_o | slide_gnt_o;
  assign wr_o        = slide_gnt_o ? slide_wr_i : alu_wr_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_slide_q <= 1'b0;
    end else if (wr_en_o) begin
      last_slide_q <= slide_gnt_o;
    end
  end

endmodule

// ==== hw/vec_lane.sv ====
`timescale 1ns/10ps

/*
 * Vector lane
 * Holds this lane's slice of the register file and runs the adder/VID
 * engine over its slots. The slide unit shares the bank write port.
 */
module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Issue
  input  pe_req_t   pe_req_i,
  input  logic      req_valid_i,
  output logic      ready_o,
  output logic      done_o,
  // Slide unit writes
  input  logic      slide_wr_valid_i,
  input  vrf_wr_t   slide_wr_i,
  output logic      slide_wr_gnt_o,
  // Slide unit reads
  input  vreg_idx_t slide_rd_reg_i,
  input  slot_idx_t slide_rd_slot_i,
  output elem_t     slide_rd_data_o
);

  elem_t     bank_q [NrVRegs][SlotsPerLane];
  pe_req_t   req_q;
  logic      busy_q;
  slot_idx_t slot_q;
  elem_t     op_a;
  elem_t     op_b;
  vrf_wr_t   alu_wr;
  logic      alu_gnt;
  logic      wr_en;
  vrf_wr_t   wr;

  ////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int s = 0; s < SlotsPerLane; s++) begin
          bank_q[r][s] <= '0;
        end
      end
    end else if (wr_en) begin
      bank_q[wr.vd][wr.slot] <= wr.data;
    end
  end

  assign slide_rd_data_o = bank_q[slide_rd_reg_i][slide_rd_slot_i];

  ////////////////////////////////////////
  // Adder and VID engine
  ////////////////////////////////////////

  assign op_a = bank_q[req_q.vs1][slot_q];
  assign op_b = bank_q[req_q.vs2][slot_q];

  always_comb begin
    alu_wr.slot = slot_q;
    alu_wr.vd   = req_q.vd;
    case (req_q.op)
      VADD_VV: alu_wr.data = op_a + op_b;
      VADD_VX: alu_wr.data = op_b + req_q.scalar;
      // Element index of this slot
      default: alu_wr.data = elem_t'(slot_q) * elem_t'(NrLanes) + elem_t'(LaneId);
    endcase
  end

  assign ready_o = ~busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      slot_q <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (!busy_q) begin
        if (req_valid_i) begin
          busy_q <= 1'b1;
          slot_q <= '0;
        end
      end else if (alu_gnt) begin
        // One slot per granted write
        slot_q <= slot_q + 1'b1;
        if (slot_q == slot_idx_t'(SlotsPerLane - 1)) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!busy_q && req_valid_i) begin
      req_q <= pe_req_i;
    end
  end

  vrf_write_arb i_write_arb (
    .clk_i         (clk_i           ),
    .rst_n_i       (rst_n_i         ),
    .alu_valid_i   (busy_q          ),
    .alu_wr_i      (alu_wr          ),
    .slide_valid_i (slide_wr_valid_i),
    .slide_wr_i    (slide_wr_i      ),
    .alu_gnt_o     (alu_gnt         ),
    .slide_gnt_o   (slide_wr_gnt_o  ),
    .wr_en_o       (wr_en           ),
    .wr_o          (wr              )
  );

endmodule

// ==== hw/vec_slide_unit.sv ====
`timescale 1ns/10ps

/*
 * Slide unit
 * Moves elements one position up across the lanes for VSLIDE1UP and
 * returns element 0 of a register to the core for VMV_XS.
 */
module vec_slide_unit import vec_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  pe_req_t               pe_req_i,
  input  logic                  req_valid_i,
  output logic                  ready_o,
  output logic                  done_o,
  output vreg_idx_t             rd_reg_o,
  output slot_idx_t             rd_slot_o,
  input  elem_t   [NrLanes-1:0] rd_data_i,
  output logic    [NrLanes-1:0] wr_valid_o,
  output vrf_wr_t [NrLanes-1:0] wr_o,
  input  logic    [NrLanes-1:0] wr_gnt_i,
  output logic                  scalar_valid_o,
  output elem_t                 scalar_data_o
);

  typedef enum logic [1:0] {
    SlIdle,
    SlSlide,
    SlRead
  } sl_state_e;

  sl_state_e             state_q;
  pe_req_t               req_q;
  slot_idx_t             slot_q;
  logic                  first_q;
  logic    [NrLanes-1:0] pend_q;
  elem_t   [NrLanes-1:0] src_q;
  elem_t   [NrLanes-1:0] src;
  elem_t                 carry_q;
  logic                  slot_done;

  assign ready_o   = (state_q == SlIdle);
  assign rd_reg_o  = req_q.vs2;
  assign rd_slot_o = slot_q;

  // Source row is sampled on the first cycle of a slot, so partial
  // grants on an in-place slide do not see their own writes
  assign src        = first_q ? rd_data_i : src_q;
  assign wr_valid_o = (state_q == SlSlide) ? pend_q : '0;
  assign slot_done  = (state_q == SlSlide) && ((pend_q & ~wr_gnt_i) == '0);

  always_comb begin
    wr_o[0].slot = slot_q;
    wr_o[0].vd   = req_q.vd;
    // Lane 0 takes the scalar, or the top lane's element of the slot below
    wr_o[0].data = (slot_q == '0) ? req_q.scalar : carry_q;
    for (int l = 1; l < NrLanes; l++) begin
      wr_o[l].slot = slot_q;
      wr_o[l].vd   = req_q.vd;
      wr_o[l].data = src[l-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q        <= SlIdle;
      slot_q         <= '0;
      first_q        <= 1'b0;
      pend_q         <= '0;
      done_o         <= 1'b0;
      scalar_valid_o <= 1'b0;
    end else begin
      done_o         <= 1'b0;
      scalar_valid_o <= 1'b0;
      case (state_q)
        SlIdle: begin
          if (req_valid_i) begin
            slot_q  <= '0;
            first_q <= 1'b1;
            pend_q  <= '1;
            state_q <= (pe_req_i.op == VMV_XS) ? SlRead : SlSlide;
          end
        end
        SlSlide: begin
          first_q <= 1'b0;
          pend_q  <= pend_q & ~wr_gnt_i;
          // Advance once every lane took its write
          if (slot_done) begin
            first_q <= 1'b1;
            pend_q  <= '1;
            slot_q  <= slot_q + 1'b1;
            if (slot_q == slot_idx_t'(SlotsPerLane - 1)) begin
              state_q <= SlIdle;
              done_o  <= 1'b1;
            end
          end
        end
        SlRead: begin
          state_q        <= SlIdle;
          done_o         <= 1'b1;
          scalar_valid_o <= 1'b1;
        end
        default: begin
          state_q <= SlIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && req_valid_i) begin
      req_q <= pe_req_i;
    end
    if (first_q) begin
      src_q <= rd_data_i;
    end
    if (slot_done) begin
      carry_q <= src[NrLanes-1];
    end
    if (state_q == SlRead) begin
      scalar_data_o <= rd_data_i[0];
    end
  end

endmodule

// ==== hw/vec_sequencer.sv ====
`timescale 1ns/10ps

/*
 * Vector sequencer
 * Register scoreboard and issue of instructions to the lane adders or
 * to the slide unit. Both targets may hold one instruction each.
 */
module vec_sequencer import vec_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  pe_req_t            insn_i,
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  output pe_req_t            pe_req_o,
  output logic               lane_req_valid_o,
  input  logic               lane_ready_i,
  output logic               slide_req_valid_o,
  input  logic               slide_ready_i,
  input  logic [NrLanes-1:0] lane_done_i,
  input  logic               slide_done_i,
  output logic               idle_o
);

  logic [NrVRegs-1:0] lane_busy_q;
  logic [NrVRegs-1:0] slide_busy_q;
  logic [NrVRegs-1:0] use_mask;
  logic [NrLanes-1:0] lane_done_q;
  pe_sel_e            target;
  logic               hazard;
  logic               lane_free;
  logic               slide_free;
  logic               xfer;
  logic               lanes_done;

  // Registers touched by the incoming instruction
  always_comb begin
    use_mask = '0;
    case (insn_i.op)
      VID: begin
        use_mask[insn_i.vd] = 1'b1;
      end
      VADD_VV: begin
        use_mask[insn_i.vd]  = 1'b1;
        use_mask[insn_i.vs1] = 1'b1;
        use_mask[insn_i.vs2] = 1'b1;
      end
      VMV_XS: begin
        use_mask[insn_i.vs2] = 1'b1;
      end
      default: begin
        use_mask[insn_i.vd]  = 1'b1;
        use_mask[insn_i.vs2] = 1'b1;
      end
    endcase
  end

  assign target     = (insn_i.op inside {VSLIDE1UP, VMV_XS}) ? PeSlide : PeLanes;
  assign hazard     = |(use_mask & (lane_busy_q | slide_busy_q));
  assign lane_free  = ~|lane_busy_q;
  assign slide_free = ~|slide_busy_q;

  assign pe_req_o          = insn_i;
  assign lane_req_valid_o  = insn_valid_i & ~hazard & lane_free & (target == PeLanes);
  assign slide_req_valid_o = insn_valid_i & ~hazard & slide_free & (target == PeSlide);
  assign insn_ready_o = ~hazard & ((target == PeLanes) ? (lane_free & lane_ready_i)
                                                       : (slide_free & slide_ready_i));
  assign xfer = insn_valid_i & insn_ready_o;

  // Lanes may finish on different cycles under write contention
  assign lanes_done = ~lane_free & (&(lane_done_q | lane_done_i));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lane_busy_q  <= '0;
      slide_busy_q <= '0;
      lane_done_q  <= '0;
    end else begin
      if (lanes_done) begin
        lane_busy_q <= '0;
        lane_done_q <= '0;
      end else begin
        lane_done_q <= lane_done_q | lane_done_i;
      end
      if (slide_done_i) begin
        slide_busy_q <= '0;
      end
      if (xfer && target == PeLanes) begin
        lane_busy_q <= use_mask;
      end
      if (xfer && target == PeSlide) begin
        slide_busy_q <= use_mask;
      end
    end
  end

  assign idle_o = ~|(lane_busy_q | slide_busy_q) & ~insn_valid_i;

endmodule

// ==== hw/vec_dispatcher.sv ====
`timescale 1ns/10ps

/*
 * Vector dispatcher
 * Four-phase req/ack handshake with the core. Hands each instruction to
 * the sequencer and returns VMV_XS results on core_rdata_o.
 */
module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Core side
  input  logic      core_req_i,
  input  vec_insn_t core_insn_i,
  output logic      core_ack_o,
  output elem_t     core_rdata_o,
  // Sequencer side
  output pe_req_t   insn_o,
  output logic      insn_valid_o,
  input  logic      insn_ready_i,
  // Scalar return from the slide unit
  input  logic      scalar_valid_i,
  input  elem_t     scalar_data_i
);

  typedef enum logic [2:0] {
    Idle,
    WaitXfer,
    WaitScalar,
    AckHigh,
    WaitReqLow
  } disp_state_e;

  disp_state_e state_q;
  disp_state_e state_d;
  vec_insn_t   insn_q;
  elem_t       rdata_q;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (core_req_i) begin
          state_d = WaitXfer;
        end
      end
      WaitXfer: begin
        // VMV_XS holds off the ack until its scalar is back
        if (insn_ready_i) begin
          state_d = (insn_q.op == VMV_XS) ? WaitScalar : AckHigh;
        end
      end
      WaitScalar: begin
        if (scalar_valid_i) begin
          state_d = AckHigh;
        end
      end
      AckHigh: begin
        state_d = WaitReqLow;
      end
      WaitReqLow: begin
        if (!core_req_i) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Instruction and returned scalar
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && core_req_i) begin
      insn_q <= core_insn_i;
    end
    if (state_q == WaitScalar && scalar_valid_i) begin
      rdata_q <= scalar_data_i;
    end
  end

  assign insn_o       = pe_req_t'(insn_q);
  assign insn_valid_o = (state_q == WaitXfer);
  assign core_ack_o   = (state_q == AckHigh) || (state_q == WaitReqLow);
  assign core_rdata_o = rdata_q;

endmodule

// ==== hw/vec_top.sv ====
`timescale 1ns/10ps

/*
 * Vector coprocessor top level
 * Connects the dispatcher, the sequencer, the lanes and the slide unit.
 */
module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      core_req_i,
  input  vec_insn_t core_insn_i,
  output logic      core_ack_o,
  output elem_t     core_rdata_o,
  output logic      vec_idle_o
);

  // Dispatcher to sequencer
  pe_req_t disp_insn;
  logic    disp_valid;
  logic    disp_ready;
  // Scalar result back to the dispatcher
  logic    scalar_valid;
  elem_t   scalar_data;
  // Issue bus
  pe_req_t            pe_req;
  logic               lane_req_valid;
  logic               slide_req_valid;
  logic               slide_ready;
  logic               slide_done;
  logic [NrLanes-1:0] lane_ready;
  logic [NrLanes-1:0] lane_done;
  // Slide unit to lanes
  vreg_idx_t            slide_rd_reg;
  slot_idx_t            slide_rd_slot;
  elem_t   [NrLanes-1:0] slide_rd_data;
  logic    [NrLanes-1:0] slide_wr_valid;
  vrf_wr_t [NrLanes-1:0] slide_wr;
  logic    [NrLanes-1:0] slide_wr_gnt;

  vec_dispatcher i_dispatcher (
    .clk_i          (clk_i       ),
    .rst_n_i        (rst_n_i     ),
    .core_req_i     (core_req_i  ),
    .core_insn_i    (core_insn_i ),
    .core_ack_o     (core_ack_o  ),
    .core_rdata_o   (core_rdata_o),
    .insn_o         (disp_insn   ),
    .insn_valid_o   (disp_valid  ),
    .insn_ready_i   (disp_ready  ),
    .scalar_valid_i (scalar_valid),
    .scalar_data_i  (scalar_data )
  );

  // Lanes accept in lockstep, so lane 0 speaks for all of them
  vec_sequencer i_sequencer (
    .clk_i             (clk_i          ),
    .rst_n_i           (rst_n_i        ),
    .insn_i            (disp_insn      ),
    .insn_valid_i      (disp_valid     ),
    .insn_ready_o      (disp_ready     ),
    .pe_req_o          (pe_req         ),
    .lane_req_valid_o  (lane_req_valid ),
    .lane_ready_i      (lane_ready[0]  ),
    .slide_req_valid_o (slide_req_valid),
    .slide_ready_i     (slide_ready    ),
    .lane_done_i       (lane_done      ),
    .slide_done_i      (slide_done     ),
    .idle_o            (vec_idle_o     )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId(l)
    ) i_lane (
      .clk_i            (clk_i            ),
      .rst_n_i          (rst_n_i          ),
      .pe_req_i         (pe_req           ),
      .req_valid_i      (lane_req_valid   ),
      .ready_o          (lane_ready[l]    ),
      .done_o           (lane_done[l]     ),
      .slide_wr_valid_i (slide_wr_valid[l]),
      .slide_wr_i       (slide_wr[l]      ),
      .slide_wr_gnt_o   (slide_wr_gnt[l]  ),
      .slide_rd_reg_i   (slide_rd_reg     ),
      .slide_rd_slot_i  (slide_rd_slot    ),
      .slide_rd_data_o  (slide_rd_data[l] )
    );
  end : gen_lanes

  vec_slide_unit i_slide_unit (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .pe_req_i       (pe_req         ),
    .req_valid_i    (slide_req_valid),
    .ready_o        (slide_ready    ),
    .done_o         (slide_done     ),
    .rd_reg_o       (slide_rd_reg   ),
    .rd_slot_o      (slide_rd_slot  ),
    .rd_data_i      (slide_rd_data  ),
    .wr_valid_o     (slide_wr_valid ),
    .wr_o           (slide_wr       ),
    .wr_gnt_i       (slide_wr_gnt   ),
    .scalar_valid_o (scalar_valid   ),
    .scalar_data_o  (scalar_data    )
  );

endmodule

// ==== test/vec_props.sv ====
`timescale 1ns/10ps

/*
 * Handshake and bank-arbiter properties
 * Bound into vec_top. Covers the four-phase core port, the dispatcher
 * valid/ready hold rule and the write arbiter of every lane.
 */
module vec_props import vec_pkg::*; (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               core_req_i,
  input logic               core_ack_i,
  input logic               insn_valid_i,
  input logic               insn_ready_i,
  input logic [NrLanes-1:0] alu_req_i,
  input logic [NrLanes-1:0] alu_gnt_i,
  input logic [NrLanes-1:0] slide_req_i,
  input logic [NrLanes-1:0] slide_gnt_i
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////
  // Four-phase core port
  ////////////////////////////////////////

  ack_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !core_ack_i)
    else begin
      $error("core_ack_o high right after reset");
      fail_cnt++;
    end

  ack_rise_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(core_ack_i) |-> core_req_i)
    else begin
      $error("core_ack_o rose while core_req_i was low");
      fail_cnt++;
    end

  ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(core_ack_i) |-> !$past(core_req_i))
    else begin
      $error("core_ack_o fell before core_req_i fell");
      fail_cnt++;
    end

  ack_held_while_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_ack_i && core_req_i |=> core_ack_i)
    else begin
      $error("core_ack_o dropped while core_req_i was still high");
      fail_cnt++;
    end

  // Dispatcher keeps valid up until the sequencer takes it
  valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    insn_valid_i && !insn_ready_i |=> insn_valid_i)
    else begin
      $error("dispatcher valid dropped before the transfer");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // Bank write arbiters
  ////////////////////////////////////////

  one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (alu_gnt_i & slide_gnt_i) == '0)
    else begin
      $error("both bank writers granted in one cycle");
      fail_cnt++;
    end

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane_props
    // A writer that lost once wins the next cycle
    alu_gnt_in_two: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      alu_req_i[l] && !alu_gnt_i[l] |=> alu_gnt_i[l])
      else begin
        $error("lane adder write not granted within two cycles");
        fail_cnt++;
      end

    slide_gnt_in_two: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slide_req_i[l] && !slide_gnt_i[l] |=> slide_gnt_i[l])
      else begin
        $error("slide write not granted within two cycles");
        fail_cnt++;
      end
  end : gen_lane_props

endmodule

bind vec_top vec_props i_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .core_req_i   (core_req_i),
  .core_ack_i   (core_ack_o),
  .insn_valid_i (disp_valid),
  .insn_ready_i (disp_ready),
  .alu_req_i    ({gen_lanes[3].i_lane.busy_q, gen_lanes[2].i_lane.busy_q,
                  gen_lanes[1].i_lane.busy_q, gen_lanes[0].i_lane.busy_q}),
  .alu_gnt_i    ({gen_lanes[3].i_lane.alu_gnt, gen_lanes[2].i_lane.alu_gnt,
                  gen_lanes[1].i_lane.alu_gnt, gen_lanes[0].i_lane.alu_gnt}),
  .slide_req_i  (slide_wr_valid),
  .slide_gnt_i  (slide_wr_gnt)
);

// ==== test/vec_tb.sv ====
`timescale 1ns/10ps

/*
 * Vector coprocessor testbench
 * Sends instructions over the four-phase core port, keeps a reference
 * register file and checks every VMV_XS result against it.
 */
module vec_tb import vec_pkg::*; ();

  logic      clk;
  logic      rst_n;
  logic      core_req;
  vec_insn_t core_insn;
  logic      core_ack;
  elem_t     core_rdata;
  logic      vec_idle;

  logic [31:0] seed       = 32'h33d4;
  int unsigned errors     = 0;
  int unsigned checks     = 0;
  int unsigned rand_iters = 20;
  elem_t       ref_vrf [NrVRegs][VLenElems];

  vec_top DUT (
    .clk_i        (clk       ),
    .rst_n_i      (rst_n     ),
    .core_req_i   (core_req  ),
    .core_insn_i  (core_insn ),
    .core_ack_o   (core_ack  ),
    .core_rdata_o (core_rdata),
    .vec_idle_o   (vec_idle  )
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic vec_insn_t make_insn(vec_op_e op, int unsigned vd, int unsigned vs1,
                                          int unsigned vs2, elem_t scalar);
    vec_insn_t insn;
    insn.op     = op;
    insn.vd     = vreg_idx_t'(vd);
    insn.vs1    = vreg_idx_t'(vs1);
    insn.vs2    = vreg_idx_t'(vs2);
    insn.scalar = scalar;
    return insn;
  endfunction

  // Reference register file update, source copied first for in-place slides
  task automatic apply_to_model(input vec_insn_t insn);
    elem_t src [VLenElems];
    for (int i = 0; i < VLenElems; i++) begin
      src[i] = ref_vrf[insn.vs2][i];
    end
    for (int i = 0; i < VLenElems; i++) begin
      case (insn.op)
        VID:       ref_vrf[insn.vd][i] = elem_t'(i);
        VADD_VV:   ref_vrf[insn.vd][i] = ref_vrf[insn.vs1][i] + src[i];
        VADD_VX:   ref_vrf[insn.vd][i] = src[i] + insn.scalar;
        VSLIDE1UP: ref_vrf[insn.vd][i] = (i == 0) ? insn.scalar : src[i-1];
        default:   ;
      endcase
    end
  endtask

  // One four-phase transfer, VMV_XS results checked while ack is high
  task automatic send_insn(input vec_insn_t insn);
    elem_t       expected;
    int unsigned waited;
    expected = ref_vrf[insn.vs2][0];
    @(posedge clk);
    core_insn <= insn;
    core_req  <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!core_ack && waited < 100);
    if (!core_ack) begin
      errors++;
      $display("core_ack_o never rose for opcode %0d within 100 cycles", insn.op);
    end else if (insn.op == VMV_XS) begin
      checks++;
      assert (core_rdata == expected) else begin
        errors++;
        $display("mismatch core_rdata_o: expected %h, got %h", expected, core_rdata);
      end
    end
    core_req <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (core_ack && waited < 100);
    if (core_ack) begin
      errors++;
      $display("core_ack_o stayed high after core_req_i fell");
    end
    apply_to_model(insn);
  endtask

  task automatic check_idle(input string burst);
    int unsigned waited;
    waited = 0;
    while (!vec_idle && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    checks++;
    assert (vec_idle) else begin
      errors++;
      $display("vec_idle_o did not rise after the %s burst", burst);
    end
  endtask

  task automatic finish_run();
    int unsigned prop_fails;
    prop_fails = DUT.i_props.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int unsigned ra;
    int unsigned rb;
    int unsigned rc;
    int unsigned rd;
    logic [31:0] pick;
    core_req  = 1'b0;
    core_insn = '0;
    rst_n     = 1'b0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VLenElems; i++) begin
        ref_vrf[r][i] = '0;
      end
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    checks++;
    assert (!core_ack) else begin
      errors++;
      $display("mismatch core_ack_o: expected 0, got %h", core_ack);
    end

    // Element index, then read back plain and slid copies
    send_insn(make_insn(VID, 1, 0, 0, '0));
    send_insn(make_insn(VMV_XS, 0, 0, 1, '0));
    send_insn(make_insn(VSLIDE1UP, 2, 0, 1, next_rand()));
    send_insn(make_insn(VMV_XS, 0, 0, 2, '0));
    send_insn(make_insn(VADD_VV, 3, 1, 2, '0));
    send_insn(make_insn(VMV_XS, 0, 0, 3, '0));
    check_idle("element index");

    // Random slide, add, read back chains
    for (int n = 0; n < rand_iters; n++) begin
      ra   = (next_rand() >> 16) % NrVRegs;
      rb   = (next_rand() >> 16) % NrVRegs;
      rc   = (next_rand() >> 16) % NrVRegs;
      rd   = (next_rand() >> 16) % NrVRegs;
      pick = next_rand();
      send_insn(make_insn(VSLIDE1UP, ra, 0, rb, next_rand()));
      if (pick[16]) begin
        send_insn(make_insn(VADD_VV, rc, ra, rd, '0));
      end else begin
        send_insn(make_insn(VADD_VX, rc, 0, ra, next_rand()));
      end
      send_insn(make_insn(VMV_XS, 0, 0, rc, '0));
    end
    check_idle("random chain");

    // Shift a whole vector out in place
    for (int n = 0; n < VLenElems; n++) begin
      send_insn(make_insn(VSLIDE1UP, 5, 0, 5, next_rand()));
    end
    send_insn(make_insn(VMV_XS, 0, 0, 5, '0));
    check_idle("full slide");

    // Slide and an independent add back to back
    send_insn(make_insn(VSLIDE1UP, 6, 0, 4, next_rand()));
    send_insn(make_insn(VADD_VV, 7, 1, 2, '0));
    send_insn(make_insn(VMV_XS, 0, 0, 6, '0));
    send_insn(make_insn(VMV_XS, 0, 0, 7, '0));
    check_idle("back to back");

    finish_run();
  end

  // Watchdog, 40 cycles of 40 ns per instruction
  initial begin
    int unsigned limit_ns;
    limit_ns = (6 + 3 * rand_iters + VLenElems + 1 + 4) * 40 * 40;
    #(limit_ns);
    errors++;
    $display("timeout: the run was still going after %0d ns", limit_ns);
    finish_run();
  end

endmodule

// ==== compile.f ====
hw/vec_pkg.sv
hw/vrf_write_arb.sv
hw/vec_lane.sv
hw/vec_slide_unit.sv
hw/vec_sequencer.sv
hw/vec_dispatcher.sv
hw/vec_top.sv
test/vec_props.sv
test/vec_tb.sv
